//--- src/board_pkg.sv
/*
 * Board package
 * Widths of the CSR bus and the GPIO vectors, reset and LED timing
 * constants, and the vector types built on them
 */
package board_pkg;

	// ------------------------------------------------------------------
	// Bus and GPIO widths
	// ------------------------------------------------------------------
	localparam int CSR_ADDR_W = 14;
	localparam int CSR_DATA_W = 32;

	// Buttons in the low bits, DIP switches above
	localparam int BTN_W = 5;
	localparam int DIP_W = 8;
	localparam int GPIO_IN_W = BTN_W + DIP_W;

	// LEDs, button LEDs and LCD lines
	localparam int GPIO_OUT_W = 14;

	// ------------------------------------------------------------------
	// Timing
	// ------------------------------------------------------------------
	// Flash/codec reset counter, top bit releases the reset
	localparam int FLASH_RST_W = 8;

	// About 10 ms of debounce at the board clock
	localparam int DEBOUNCE_W_DEF = 20;

	// Long enough for a single UART bit to be seen
	localparam int STRETCH_W_DEF = 19;

	// ------------------------------------------------------------------
	// Vector types
	// ------------------------------------------------------------------
	typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
	typedef logic [CSR_DATA_W-1:0] csr_data_t;
	typedef logic [GPIO_IN_W-1:0]  gpio_in_t;
	typedef logic [GPIO_OUT_W-1:0] gpio_out_t;

endpackage

//--- src/csr_map_pkg.sv
/*
 * CSR map package
 * Block select of the GPIO controller on the CSR bus, its register
 * offsets and the read-only system ID
 */
package csr_map_pkg;

	// ------------------------------------------------------------------
	// Address fields
	// ------------------------------------------------------------------
	// Block select lives in address bits 13..10
	typedef logic [3:0] csr_blk_t;

	// Word offset inside a block, address bits 1..0
	typedef logic [1:0] csr_reg_t;

	// ------------------------------------------------------------------
	// GPIO controller
	// ------------------------------------------------------------------
	localparam csr_blk_t GPIO_CSR_BLOCK = 4'h1;

	// Register offsets
	localparam csr_reg_t REG_GPIO_IN   = 2'd0;
	localparam csr_reg_t REG_GPIO_OUT  = 2'd1;
	localparam csr_reg_t REG_IRQ_EN    = 2'd2;
	localparam csr_reg_t REG_SYSTEM_ID = 2'd3;

	// Board identification, reads back as ASCII "BSC1"
	localparam logic [31:0] SYSTEM_ID = 32'h42534331;

endpackage

//--- src/reset_seq.sv
/*
 * Reset sequencer
 * Debounces the board reset into a long system reset and releases
 * the flash/codec reset well before the system reset ends
 */
`timescale 1ns/1ps

module reset_seq
	import board_pkg::*;
#(
	parameter int DEBOUNCE_W = DEBOUNCE_W_DEF
) (
	input  logic sys_clk,
	input  logic rst1,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	// Board reset seen one cycle late, arms the debounce count
	logic rst1_q;

	logic [DEBOUNCE_W-1:0]  debounce_cnt;
	logic [FLASH_RST_W-1:0] flash_cnt;

	// ------------------------------------------------------------------
	// Debounce
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		rst1_q <= rst1;
	end

	// Any low level on the board reset restarts the full count
	always_ff @(posedge sys_clk) begin
		if (!rst1 || !rst1_q) begin
			debounce_cnt <= '1;
		end else if (debounce_cnt != '0) begin
			debounce_cnt <= debounce_cnt - DEBOUNCE_W'(1);
		end
	end

	// System reset held until the count has run out
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			sys_rst_o <= 1'b1;
		end else begin
			sys_rst_o <= (debounce_cnt != '0);
		end
	end

	// ------------------------------------------------------------------
	// Flash/codec reset
	// ------------------------------------------------------------------
	// Boot flash needs time to wake up before the CPU fetches from it
	// Codec wants its reset held for about a microsecond
	always_ff @(posedge sys_clk) begin
		if (!rst1) begin
			flash_cnt <= '0;
		end else if (!flash_cnt[FLASH_RST_W-1]) begin
			flash_cnt <= flash_cnt + FLASH_RST_W'(1);
		end
	end

	// Top bit sticks once set
	assign flash_rst_n_o = flash_cnt[FLASH_RST_W-1];

endmodule

//--- src/activity_led.sv
/*
 * Activity LED
 * Stretches low pulses of a serial line into an LED pulse long
 * enough to see
 */
`timescale 1ns/1ps

module activity_led
	import board_pkg::*;
#(
	parameter int STRETCH_W = STRETCH_W_DEF
) (
	input  logic sys_clk,
	input  logic rst1,
	input  logic line_i,
	output logic led_o
);

	logic [STRETCH_W-1:0] stretch_cnt;
	logic                 trigger;

	// Start bits and zero bits both retrigger
	// Board reset also lights the LED as a lamp test
	assign trigger = !rst1 || !line_i;

	always_ff @(posedge sys_clk) begin
		if (trigger) begin
			stretch_cnt <= '1;
		end else if (stretch_cnt != '0) begin
			stretch_cnt <= stretch_cnt - STRETCH_W'(1);
		end
	end

	// Registered LED drive
	// lights on the first edge of a low level, not one later
	always_ff @(posedge sys_clk) begin
		led_o <= trigger || (stretch_cnt != '0);
	end

endmodule

//--- src/gpio_in_sync.sv
/*
 * GPIO input synchronizer
 * Brings buttons and switches into the clock domain and flags a
 * change of any enabled input with a one-cycle interrupt
 */
`timescale 1ns/1ps

module gpio_in_sync
	import board_pkg::*;
(
	input  logic     sys_clk,
	input  logic     sys_rst_i,
	input  gpio_in_t gpio_i,
	input  gpio_in_t irq_en_i,
	output gpio_in_t gpio_sync_o,
	output logic     gpio_irq_o
);

	// Two flops against metastability, then the previous sample
	gpio_in_t sync_q1;
	gpio_in_t sync_q2;
	gpio_in_t prev_q;
	gpio_in_t changed;

	// ------------------------------------------------------------------
	// Synchronizer
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		sync_q1 <= gpio_i;
		sync_q2 <= sync_q1;
		prev_q  <= sync_q2;
	end

	assign gpio_sync_o = sync_q2;

	// ------------------------------------------------------------------
	// Change detect
	// ------------------------------------------------------------------
	// Edges in either direction, masked by the enables
	assign changed = (sync_q2 ^ prev_q) & irq_en_i;

	// One pulse per change, lands on the third edge after the input
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_irq_o <= 1'b0;
		end else begin
			gpio_irq_o <= |changed;
		end
	end

endmodule

//--- src/gpio_csr.sv
/*
 * GPIO CSR block
 * Input read-back, output register, interrupt enable mask and the
 * system ID, on the plain CSR bus with registered read data
 */
`timescale 1ns/1ps

module gpio_csr
	import board_pkg::*;
	import csr_map_pkg::*;
(
	input  logic      sys_clk,
	input  logic      sys_rst_i,
	input  csr_addr_t csr_a_i,
	input  logic      csr_we_i,
	input  csr_data_t csr_dw_i,
	input  gpio_in_t  gpio_sync_i,
	output csr_data_t csr_dr_o,
	output gpio_out_t gpio_out_o,
	output gpio_in_t  irq_en_o
);

	logic      blk_sel;
	logic      csr_wr;
	csr_reg_t  reg_off;
	csr_data_t rd_data;

	// ------------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------------
	// Bits 9..2 are not decoded, registers alias across the block
	assign blk_sel = (csr_a_i[13:10] == GPIO_CSR_BLOCK);
	assign reg_off = csr_a_i[1:0];
	assign csr_wr  = csr_we_i && blk_sel;

	// ------------------------------------------------------------------
	// Writable registers
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out_o <= '0;
			irq_en_o   <= '0;
		end else if (csr_wr) begin
			case (reg_off)
				REG_GPIO_OUT: begin
					gpio_out_o <= csr_dw_i[GPIO_OUT_W-1:0];
				end
				REG_IRQ_EN: begin
					irq_en_o <= csr_dw_i[GPIO_IN_W-1:0];
				end
				// Inputs and ID are read-only
				default: begin
				end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Read path
	// ------------------------------------------------------------------
	// Narrow registers zero-extended to the bus
	always_comb begin
		case (reg_off)
			REG_GPIO_IN: begin
				rd_data = csr_data_t'(gpio_sync_i);
			end
			REG_GPIO_OUT: begin
				rd_data = csr_data_t'(gpio_out_o);
			end
			REG_IRQ_EN: begin
				rd_data = csr_data_t'(irq_en_o);
			end
			default: begin
				rd_data = SYSTEM_ID;
			end
		endcase
	end

	// Zero when not selected
	// lets the bus master OR all blocks together
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			csr_dr_o <= '0;
		end else if (blk_sel) begin
			csr_dr_o <= rd_data;
		end else begin
			csr_dr_o <= '0;
		end
	end

endmodule

//--- src/board_top.sv
/*
 * Board system glue
 * Reset conditioning, UART activity LEDs, the GPIO controller and
 * the mapping of its outputs onto LEDs and the LCD
 */
`timescale 1ns/1ps

module board_top
	import board_pkg::*;
#(
	parameter int DEBOUNCE_W = DEBOUNCE_W_DEF,
	parameter int STRETCH_W  = STRETCH_W_DEF
) (
	input  logic             sys_clk,
	input  logic             rst1,

	// Front panel
	input  logic [BTN_W-1:0] btn_i,
	input  logic [DIP_W-1:0] dipsw_i,

	// Serial lines, monitored only
	input  logic             uart_rxd_i,
	input  logic             uart_txd_i,

	// CSR bus
	input  csr_addr_t        csr_a_i,
	input  logic             csr_we_i,
	input  csr_data_t        csr_dw_i,
	output csr_data_t        csr_dr_o,

	// Resets and interrupt
	output logic             sys_rst_o,
	output logic             flash_rst_n_o,
	output logic             gpio_irq_o,

	// LEDs and LCD
	output logic [3:0]       led_o,
	output logic [BTN_W-1:0] btnled_o,
	output logic             lcd_e_o,
	output logic             lcd_rs_o,
	output logic             lcd_rw_o,
	output logic [3:0]       lcd_d_o
);

	logic      tx_act;
	logic      rx_act;
	gpio_in_t  gpio_in;
	gpio_in_t  gpio_sync;
	gpio_in_t  irq_en;
	gpio_out_t gpio_out;

	// ------------------------------------------------------------------
	// Resets
	// ------------------------------------------------------------------
	reset_seq #(
		.DEBOUNCE_W(DEBOUNCE_W)
	) u_reset_seq (
		.sys_clk      (sys_clk),
		.rst1         (rst1),
		.sys_rst_o    (sys_rst_o),
		.flash_rst_n_o(flash_rst_n_o)
	);

	// ------------------------------------------------------------------
	// UART activity
	// ------------------------------------------------------------------
	activity_led #(
		.STRETCH_W(STRETCH_W)
	) tx_led (
		.sys_clk(sys_clk),
		.rst1   (rst1),
		.line_i (uart_txd_i),
		.led_o  (tx_act)
	);

	activity_led #(
		.STRETCH_W(STRETCH_W)
	) rx_led (
		.sys_clk(sys_clk),
		.rst1   (rst1),
		.line_i (uart_rxd_i),
		.led_o  (rx_act)
	);

	// ------------------------------------------------------------------
	// GPIO controller
	// ------------------------------------------------------------------
	// DIP switches above the buttons
	assign gpio_in = {dipsw_i, btn_i};

	gpio_in_sync u_gpio_in_sync (
		.sys_clk    (sys_clk),
		.sys_rst_i  (sys_rst_o),
		.gpio_i     (gpio_in),
		.irq_en_i   (irq_en),
		.gpio_sync_o(gpio_sync),
		.gpio_irq_o (gpio_irq_o)
	);

	gpio_csr u_gpio_csr (
		.sys_clk    (sys_clk),
		.sys_rst_i  (sys_rst_o),
		.csr_a_i    (csr_a_i),
		.csr_we_i   (csr_we_i),
		.csr_dw_i   (csr_dw_i),
		.gpio_sync_i(gpio_sync),
		.csr_dr_o   (csr_dr_o),
		.gpio_out_o (gpio_out),
		.irq_en_o   (irq_en)
	);

	// ------------------------------------------------------------------
	// Output mapping
	// ------------------------------------------------------------------
	// LED0 TX, LED1 RX, upper two from software
	assign led_o    = {gpio_out[1:0], rx_act, tx_act};
	assign btnled_o = gpio_out[6:2];

	// LCD in 4-bit mode
	assign lcd_e_o  = gpio_out[7];
	assign lcd_rs_o = gpio_out[8];
	assign lcd_rw_o = gpio_out[9];
	assign lcd_d_o  = gpio_out[13:10];

endmodule

//--- test/board_top_asserts.sv
/*
 * Board assertions
 * Concurrent checks on the reset sequencer and the GPIO CSR block,
 * bound into the board top level where both sit
 */
`timescale 1ns/1ps

module board_top_asserts
	import board_pkg::*;
	import csr_map_pkg::*;
(
	input logic      sys_clk,
	input logic      rst1,
	input logic      sys_rst_i,
	input logic      flash_rst_n_i,
	input csr_addr_t csr_a_i,
	input csr_data_t csr_dr_i,
	input gpio_out_t gpio_out_i
);

	int fail_count = 0;

	// Unselected block drives zero so read data can be OR-combined
	csr_dr_zero: assert property (
		@(posedge sys_clk) disable iff (!rst1)
		(csr_a_i[13:10] != GPIO_CSR_BLOCK) |=> (csr_dr_i == '0)
	) else begin
		fail_count++;
		$error("CSR read data not zero after an unselected address");
	end

	// First reset edge only arms the register
	out_in_reset: assert property (
		@(posedge sys_clk)
		(sys_rst_i && $past(sys_rst_i)) |-> (gpio_out_i == '0)
	) else begin
		fail_count++;
		$error("GPIO outputs not zero during system reset");
	end

	flash_held: assert property (
		@(posedge sys_clk)
		$rose(flash_rst_n_i) |-> $past(rst1)
	) else begin
		fail_count++;
		$error("Flash reset released while board reset low");
	end

endmodule

bind board_top board_top_asserts u_asserts (
	.sys_clk      (sys_clk),
	.rst1         (rst1),
	.sys_rst_i    (sys_rst_o),
	.flash_rst_n_i(flash_rst_n_o),
	.csr_a_i      (csr_a_i),
	.csr_dr_i     (csr_dr_o),
	.gpio_out_i   (gpio_out)
);

//--- test/board_top_tb.sv
/*
 * Board system glue testbench
 * Directed tests of reset sequencing, CSR access, output mapping,
 * input read-back with interrupt, and the UART activity LEDs
 */
`timescale 1ns/1ps

module board_top_tb
	import board_pkg::*;
	import csr_map_pkg::*;
();

	localparam int DEBOUNCE_W = 6;
	localparam int STRETCH_W  = 5;
	// Tests take about 430 cycles, limit leaves a wide margin
	localparam int MAX_CYCLES = 3000;
	localparam csr_data_t OUT_MASK = {{(CSR_DATA_W-GPIO_OUT_W){1'b0}}, {GPIO_OUT_W{1'b1}}};
	localparam csr_data_t IN_MASK  = {{(CSR_DATA_W-GPIO_IN_W){1'b0}}, {GPIO_IN_W{1'b1}}};

	logic             sys_clk;
	logic             rst1;
	logic [BTN_W-1:0] btn_i;
	logic [DIP_W-1:0] dipsw_i;
	logic             uart_rxd_i;
	logic             uart_txd_i;
	csr_addr_t        csr_a_i;
	logic             csr_we_i;
	csr_data_t        csr_dw_i;
	csr_data_t        csr_dr_o;
	logic             sys_rst_o;
	logic             flash_rst_n_o;
	logic             gpio_irq_o;
	logic [3:0]       led_o;
	logic [BTN_W-1:0] btnled_o;
	logic             lcd_e_o;
	logic             lcd_rs_o;
	logic             lcd_rw_o;
	logic [3:0]       lcd_d_o;

	logic [31:0] rand_state = 32'h317a17c5;
	int          cycle_count = 0;

	board_top #(
		.DEBOUNCE_W(DEBOUNCE_W),
		.STRETCH_W (STRETCH_W)
	) dut (.*);

	// ------------------------------------------------------------------
	// Clock and run limit
	// ------------------------------------------------------------------
	initial begin
		sys_clk = 1'b0;
		forever begin
			#50 sys_clk = ~sys_clk;
		end
	end

	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (dut.u_asserts.fail_count != 0) begin
			$display("Errors found");
			$fatal(1);
		end else if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout, a test did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$fatal(1);
		end
	end

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------
	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	// Block select on top, offset at the bottom, middle bits unused
	function automatic csr_addr_t reg_addr(input logic [3:0] blk, input logic [1:0] off);
		return {blk, 8'h00, off};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// All bus tasks start and end just after a falling edge
	task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
		csr_a_i  = addr;
		csr_we_i = 1'b1;
		csr_dw_i = data;
		@(negedge sys_clk);
		csr_we_i = 1'b0;
	endtask

	// Read data is registered, valid one edge after the address
	task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
		csr_a_i  = addr;
		csr_we_i = 1'b0;
		@(negedge sys_clk);
		data = csr_dr_o;
	endtask

	task automatic toggle_input(input int idx);
		if (idx < BTN_W) btn_i[idx] = ~btn_i[idx];
		else dipsw_i[idx-BTN_W] = ~dipsw_i[idx-BTN_W];
	endtask

	// Count interrupt pulses over six edges after an input change
	task automatic watch_irq(output int pulses, output int edge_at);
		pulses = 0;
		edge_at = 0;
		for (int k = 1; k <= 6; k++) begin
			@(negedge sys_clk);
			if (gpio_irq_o) begin
				pulses++;
				edge_at = k;
			end
		end
	endtask

	// ------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------
	task automatic test_reset();
		int flash_edge;
		int rst_edge;
		flash_edge = 0;
		rst_edge = 0;
		check_value("sys_rst_o", sys_rst_o, 1);
		check_value("flash_rst_n_o", flash_rst_n_o, 0);
		check_value("gpio_irq_o", gpio_irq_o, 0);
		check_value("led_o[3:2]", led_o[3:2], 0);
		check_value("btnled_o", btnled_o, 0);
		check_value("lcd lines", {lcd_d_o, lcd_rw_o, lcd_rs_o, lcd_e_o}, 0);
		// Write all ones to the outputs while the system reset still holds
		csr_a_i  = reg_addr(GPIO_CSR_BLOCK, REG_GPIO_OUT);
		csr_dw_i = '1;
		csr_we_i = 1'b1;
		rst1 = 1'b1;
		// Edge 1 is the first rising edge that sees the board reset high
		for (int k = 1; k <= 200; k++) begin
			@(negedge sys_clk);
			if (k == 4) begin
				csr_we_i = 1'b0;
				check_value("led_o[3:2] in reset", led_o[3:2], 0);
				check_value("btnled_o in reset", btnled_o, 0);
				check_value("lcd_d_o in reset", lcd_d_o, 0);
			end
			if (flash_rst_n_o && flash_edge == 0) flash_edge = k;
			if (!sys_rst_o && rst_edge == 0) rst_edge = k;
		end
		check_value("flash_rst_n_o rise edge", flash_edge, 2**(FLASH_RST_W-1));
		check_value("sys_rst_o fall edge", rst_edge, 2**DEBOUNCE_W + 1);
		check_value("flash_rst_n_o", flash_rst_n_o, 1);
		check_value("sys_rst_o", sys_rst_o, 0);
		// Stretch time long over, activity LEDs dark
		check_value("led_o", led_o, 0);
	endtask

	task automatic test_csr_access();
		csr_data_t rd;
		csr_data_t out_val;
		csr_data_t en_val;
		logic [3:0] blk;
		csr_read(reg_addr(GPIO_CSR_BLOCK, REG_SYSTEM_ID), rd);
		check_value("csr_dr_o SYSTEM_ID", rd, SYSTEM_ID);
		repeat (8) begin
			out_val = next_random();
			en_val = next_random();
			csr_write(reg_addr(GPIO_CSR_BLOCK, REG_GPIO_OUT), out_val);
			csr_write(reg_addr(GPIO_CSR_BLOCK, REG_IRQ_EN), en_val);
			csr_read(reg_addr(GPIO_CSR_BLOCK, REG_GPIO_OUT), rd);
			check_value("csr_dr_o GPIO_OUT", rd, out_val & OUT_MASK);
			csr_read(reg_addr(GPIO_CSR_BLOCK, REG_IRQ_EN), rd);
			check_value("csr_dr_o IRQ_EN", rd, en_val & IN_MASK);
		end
		// Another block: reads zero, its write lands nowhere here
		blk = 4'(next_random());
		if (blk == GPIO_CSR_BLOCK) blk = 4'h2;
		csr_write(reg_addr(blk, REG_GPIO_OUT), ~out_val);
		csr_read(reg_addr(blk, REG_SYSTEM_ID), rd);
		check_value("csr_dr_o other block", rd, 0);
		csr_read(reg_addr(GPIO_CSR_BLOCK, REG_GPIO_OUT), rd);
		check_value("csr_dr_o GPIO_OUT", rd, out_val & OUT_MASK);
		// ID is read-only
		csr_write(reg_addr(GPIO_CSR_BLOCK, REG_SYSTEM_ID), next_random());
		csr_read(reg_addr(GPIO_CSR_BLOCK, REG_SYSTEM_ID), rd);
		check_value("csr_dr_o SYSTEM_ID", rd, SYSTEM_ID);
		// The ID write must not land in the writable registers
		csr_read(reg_addr(GPIO_CSR_BLOCK, REG_GPIO_OUT), rd);
		check_value("csr_dr_o GPIO_OUT", rd, out_val & OUT_MASK);
		csr_read(reg_addr(GPIO_CSR_BLOCK, REG_IRQ_EN), rd);
		check_value("csr_dr_o IRQ_EN", rd, en_val & IN_MASK);
		csr_write(reg_addr(GPIO_CSR_BLOCK, REG_IRQ_EN), '0);
	endtask

	task automatic test_output_map();
		csr_data_t val;
		repeat (8) begin
			val = next_random() & OUT_MASK;
			csr_write(reg_addr(GPIO_CSR_BLOCK, REG_GPIO_OUT), val);
			check_value("led_o[3:2]", led_o[3:2], val[1:0]);
			check_value("btnled_o", btnled_o, val[6:2]);
			check_value("lcd_e_o", lcd_e_o, val[7]);
			check_value("lcd_rs_o", lcd_rs_o, val[8]);
			check_value("lcd_rw_o", lcd_rw_o, val[9]);
			check_value("lcd_d_o", lcd_d_o, val[13:10]);
		end
		csr_write(reg_addr(GPIO_CSR_BLOCK, REG_GPIO_OUT), '0);
	endtask

	task automatic test_inputs_irq();
		csr_data_t rd;
		logic [31:0] val;
		int bit_en;
		int bit_off;
		int pulses;
		int edge_at;
		repeat (8) begin
			val = next_random();
			btn_i = val[BTN_W-1:0];
			dipsw_i = val[15:8];
			// Two synchronizer stages before the register sees it
			repeat (2) @(negedge sys_clk);
			csr_read(reg_addr(GPIO_CSR_BLOCK, REG_GPIO_IN), rd);
			check_value("csr_dr_o GPIO_IN", rd, {val[15:8], val[BTN_W-1:0]});
			check_value("gpio_irq_o", gpio_irq_o, 0);
		end
		bit_en = next_random() % GPIO_IN_W;
		bit_off = (bit_en + 1 + next_random() % (GPIO_IN_W - 1)) % GPIO_IN_W;
		csr_write(reg_addr(GPIO_CSR_BLOCK, REG_IRQ_EN), 32'd1 << bit_en);
		repeat (3) @(negedge sys_clk);
		// Both directions of change on the enabled bit
		repeat (2) begin
			toggle_input(bit_en);
			watch_irq(pulses, edge_at);
			check_value("gpio_irq_o pulse count", pulses, 1);
			check_value("gpio_irq_o pulse edge", edge_at, 3);
		end
		toggle_input(bit_off);
		watch_irq(pulses, edge_at);
		check_value("gpio_irq_o pulse count masked", pulses, 0);
		csr_write(reg_addr(GPIO_CSR_BLOCK, REG_IRQ_EN), '0);
	endtask

	// sel 0 is TX on LED0, sel 1 is RX on LED1
	task automatic test_activity_led(input int sel);
		int fall_edge;
		fall_edge = 0;
		check_value("led_o", led_o, 0);
		if (sel == 1) uart_rxd_i = 1'b0;
		else uart_txd_i = 1'b0;
		@(negedge sys_clk);
		uart_rxd_i = 1'b1;
		uart_txd_i = 1'b1;
		check_value("led_o lit", led_o[sel], 1);
		// Edge 1 sampled the low bit, counter runs out 2^STRETCH_W edges on
		for (int k = 2; k <= 40; k++) begin
			@(negedge sys_clk);
			if (!led_o[sel] && fall_edge == 0) fall_edge = k;
			check_value("led_o other line", led_o[1-sel], 0);
		end
		check_value("led_o fall edge", fall_edge, 2**STRETCH_W + 1);
	endtask

	initial begin
		rst1       = 1'b0;
		btn_i      = '0;
		dipsw_i    = '0;
		uart_rxd_i = 1'b1;
		uart_txd_i = 1'b1;
		csr_a_i    = '0;
		csr_we_i   = 1'b0;
		csr_dw_i   = '0;
		repeat (5) @(negedge sys_clk);
		test_reset();
		test_csr_access();
		test_output_map();
		test_inputs_irq();
		test_activity_led(1);
		test_activity_led(0);
		if (dut.u_asserts.fail_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1);
		end
	end

endmodule

//--- board_sysctl.f
src/board_pkg.sv
src/csr_map_pkg.sv
src/reset_seq.sv
src/activity_led.sv
src/gpio_in_sync.sv
src/gpio_csr.sv
src/board_top.sv
test/board_top_asserts.sv
test/board_top_tb.sv

//--- Bender.yml
package:
  name: board_sysctl

sources:
  - src/board_pkg.sv
  - src/csr_map_pkg.sv
  - src/reset_seq.sv
  - src/activity_led.sv
  - src/gpio_in_sync.sv
  - src/gpio_csr.sv
  - src/board_top.sv
  - target: test
    files:
      - test/board_top_asserts.sv
      - test/board_top_tb.sv
